// File: common/timekeeper_pkg.sv
/* time keeper shared definitions.
   register map, axi response codes and the structs passed between blocks. */
package timekeeper_pkg;

   // 64-bit sample time, one count per clock.
   typedef logic [63:0] time_t;

   // byte offsets in the 8-bit register space.
   // pending load value, read/write.
   localparam logic [7:0] reg_time_hi   = 8'h00;
   localparam logic [7:0] reg_time_lo   = 8'h04;

   // control word, write only.
   // bit 0 is load-now, bit 1 is load-at-pps.
   localparam logic [7:0] reg_time_ctrl = 8'h08;

   // current time, read only.
   // low word first, the high word comes from the hold register.
   localparam logic [7:0] reg_now_lo    = 8'h10;
   localparam logic [7:0] reg_now_hi    = 8'h14;

   // time at the last pps edge, read only.
   localparam logic [7:0] reg_pps_lo    = 8'h18;
   localparam logic [7:0] reg_pps_hi    = 8'h1C;

   // control word bit positions.
   localparam int ctrl_now_bit    = 0;
   localparam int ctrl_at_pps_bit = 1;

   // axi4-lite response codes.
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

   // load request from the register slave to the counter.
   // arm is a one cycle pulse per control write.
   typedef struct packed {
      time_t value;
      logic  now;
      logic  at_pps;
      logic  arm;
   } time_load_t;

   // counter state reported back to the slave and the top level.
   typedef struct packed {
      time_t vita_time;
      time_t vita_time_lastpps;
   } time_status_t;

endpackage

// File: logic/pps_detect.sv
`timescale 1ns/1ps
/* pps edge detector.
   synchronizes the external pps and emits a one cycle pulse on each rise. */
module pps_detect #(
   parameter int sync_stages = 2
) (
   input  logic clk,
   input  logic reset,
   input  logic pps,
   output logic pps_edge
);

   // synchronizer chain, bit 0 samples the raw input.
   logic [sync_stages-1:0] pps_sync;
   // last stage delayed once more for the edge compare.
   logic pps_last;

   always_ff @(posedge clk) begin
      if (reset) begin
         pps_sync <= '0;
         pps_last <= 1'b0;
         pps_edge <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[sync_stages-2:0], pps};
         pps_last <= pps_sync[sync_stages-1];
         // registered rise, high for exactly one cycle.
         pps_edge <= pps_sync[sync_stages-1] & ~pps_last;
      end
   end

   // a rise needs a low before it, so two pulses cannot touch.
   pps_edge_single: assert property (@(posedge clk) disable iff (reset)
      pps_edge |=> !pps_edge)
      else $error("pps_edge high on two consecutive cycles");

endmodule

// File: timekeeper/timekeeper_regs.sv
`timescale 1ns/1ps
/* time keeper register slave.
   axi4-lite access to the pending time and the control word, with
   consistent 64-bit reads of the running and last-pps times. */
module timekeeper_regs
   import timekeeper_pkg::*;
#(
   parameter int addr_width = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   // write address and data.
   input  logic [addr_width-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [31:0]           wdata,
   input  logic [3:0]            wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   // write response.
   output axi_resp_t             bresp,
   output logic                  bvalid,
   input  logic                  bready,
   // read address and data.
   input  logic [addr_width-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output logic [31:0]           rdata,
   output axi_resp_t             rresp,
   output logic                  rvalid,
   input  logic                  rready,
   // counter side.
   output time_load_t            load,
   input  time_status_t          status
);

   // pending load value.
   logic [31:0] time_hi;
   logic [31:0] time_lo;
   // latched control bits and the arm pulse.
   logic        ctrl_now;
   logic        ctrl_at_pps;
   logic        arm;
   // high word saved by a low word status read.
   logic [31:0] hold;

   logic        wr_accept;
   logic        wr_ok;
   logic        wr_is_hi;
   logic        wr_is_lo;
   logic        wr_is_ctrl;
   logic        rd_accept;
   logic        rd_ok;
   logic        rd_capture;
   logic [31:0] rd_data;
   logic [31:0] rd_hold;

   // handshakes complete while the registered ready is high.
   assign wr_accept = awvalid & awready & wvalid & wready;
   assign rd_accept = arvalid & arready;

   // write decode, only the three read/write offsets take data.
   always_comb begin
      wr_is_hi   = 1'b0;
      wr_is_lo   = 1'b0;
      wr_is_ctrl = 1'b0;
      case (awaddr)
         addr_width'(reg_time_hi):   wr_is_hi   = 1'b1;
         addr_width'(reg_time_lo):   wr_is_lo   = 1'b1;
         addr_width'(reg_time_ctrl): wr_is_ctrl = 1'b1;
         default: ;
      endcase
   end

   // partial strobes are refused as a whole.
   assign wr_ok = (&wstrb) & (wr_is_hi | wr_is_lo | wr_is_ctrl);

   // write channel control and register state.
   always_ff @(posedge clk) begin
      if (reset) begin
         awready     <= 1'b0;
         wready      <= 1'b0;
         bvalid      <= 1'b0;
         time_hi     <= '0;
         time_lo     <= '0;
         ctrl_now    <= 1'b0;
         ctrl_at_pps <= 1'b0;
         arm         <= 1'b0;
      end else begin
         // ready for one cycle once both channels are valid and no response waits.
         awready <= awvalid & wvalid & ~bvalid & ~awready;
         wready  <= awvalid & wvalid & ~bvalid & ~awready;
         arm     <= 1'b0;
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
         if (wr_accept) begin
            bvalid <= 1'b1;
            if (wr_ok && wr_is_hi) begin
               time_hi <= wdata;
            end
            if (wr_ok && wr_is_lo) begin
               time_lo <= wdata;
            end
            // every control write arms a new load.
            if (wr_ok && wr_is_ctrl) begin
               ctrl_now    <= wdata[ctrl_now_bit];
               ctrl_at_pps <= wdata[ctrl_at_pps_bit];
               arm         <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_accept) begin
         bresp <= wr_ok ? resp_okay : resp_slverr;
      end
   end

   // read decode; _hi status offsets return the hold register.
   always_comb begin
      rd_data    = '0;
      rd_hold    = hold;
      rd_ok      = 1'b1;
      rd_capture = 1'b0;
      case (araddr)
         addr_width'(reg_time_hi): rd_data = time_hi;
         addr_width'(reg_time_lo): rd_data = time_lo;
         addr_width'(reg_now_lo): begin
            rd_data    = status.vita_time[31:0];
            rd_hold    = status.vita_time[63:32];
            rd_capture = 1'b1;
         end
         addr_width'(reg_pps_lo): begin
            rd_data    = status.vita_time_lastpps[31:0];
            rd_hold    = status.vita_time_lastpps[63:32];
            rd_capture = 1'b1;
         end
         addr_width'(reg_now_hi),
         addr_width'(reg_pps_hi): rd_data = hold;
         // control is write only, the rest is unmapped.
         default: rd_ok = 1'b0;
      endcase
   end

   // read channel control.
   always_ff @(posedge clk) begin
      if (reset) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         arready <= arvalid & ~rvalid & ~arready;
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
         if (rd_accept) begin
            rvalid <= 1'b1;
         end
      end
   end

   // read data and the hold register.
   always_ff @(posedge clk) begin
      if (rd_accept) begin
         rdata <= rd_data;
         rresp <= rd_ok ? resp_okay : resp_slverr;
         if (rd_capture) begin
            hold <= rd_hold;
         end
      end
   end

   assign load = '{value: {time_hi, time_lo}, now: ctrl_now, at_pps: ctrl_at_pps, arm: arm};

   // a response stays up until the master takes it.
   bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped without bready");

   // one control write gives one arm cycle.
   arm_single: assert property (@(posedge clk) disable iff (reset)
      arm |=> !arm)
      else $error("arm lasted two cycles");

endmodule

// File: timekeeper/time_counter.sv
`timescale 1ns/1ps
/* time counter.
   free running 64-bit time with armed loads and the last-pps capture. */
module time_counter
   import timekeeper_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  time_load_t   load,
   input  logic         pps_edge,
   output time_status_t status
);

   // a load waits here until its condition is met.
   logic  armed;
   logic  load_event;
   time_t vita_time;
   time_t vita_time_lastpps;
   // value the counter takes on the next edge.
   time_t next_time;

   // load now fires on the first armed cycle, load at pps waits for the edge.
   assign load_event = armed & (load.now | (load.at_pps & pps_edge));
   assign next_time  = load_event ? load.value : vita_time + 64'd1;

   always_ff @(posedge clk) begin
      if (reset) begin
         armed <= 1'b0;
      end else if (load.arm) begin
         armed <= 1'b1;
      end else if (load_event) begin
         armed <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time <= '0;
      end else begin
         vita_time <= next_time;
      end
   end

   // pps capture follows the counter, so a coinciding load is seen here too.
   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time_lastpps <= '0;
      end else if (pps_edge) begin
         vita_time_lastpps <= next_time;
      end
   end

   assign status = '{vita_time: vita_time, vita_time_lastpps: vita_time_lastpps};

   // time only jumps on a load.
   count_step: assert property (@(posedge clk) disable iff (reset)
      !load_event |=> vita_time == $past(vita_time) + 64'd1)
      else $error("vita_time did not advance by one");

endmodule

// File: timekeeper/timekeeper_top.sv
`timescale 1ns/1ps
/* time keeper top level.
   joins the axi register slave, the pps detector and the time counter. */
module timekeeper_top
   import timekeeper_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         pps,
   // axi4-lite slave.
   input  logic [7:0]   awaddr,
   input  logic         awvalid,
   output logic         awready,
   input  logic [31:0]  wdata,
   input  logic [3:0]   wstrb,
   input  logic         wvalid,
   output logic         wready,
   output axi_resp_t    bresp,
   output logic         bvalid,
   input  logic         bready,
   input  logic [7:0]   araddr,
   input  logic         arvalid,
   output logic         arready,
   output logic [31:0]  rdata,
   output axi_resp_t    rresp,
   output logic         rvalid,
   input  logic         rready,
   // time outputs to the datapath.
   output time_t        vita_time,
   output time_t        vita_time_lastpps
);

   time_load_t   load;
   time_status_t status;
   logic         pps_edge;

   timekeeper_regs #(.addr_width(8)) timekeeper_regs_i (
      .clk, .reset,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .load, .status
   );

   // two stage synchronizer for the external pps.
   pps_detect #(.sync_stages(2)) pps_detect_i (.clk, .reset, .pps, .pps_edge);

   time_counter time_counter_i (.clk, .reset, .load, .pps_edge, .status);

   assign vita_time         = status.vita_time;
   assign vita_time_lastpps = status.vita_time_lastpps;

endmodule

// File: verif/timekeeper_tests.svh
/* time keeper test sequence.
   free running, load now, load at pps, last-pps capture and register access. */

task automatic test_start();
   errors_at_start = errors;
endtask

task automatic test_end(input string name);
   if (errors == errors_at_start) begin
      tests_passed++;
      $display("%s: ok", name);
   end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errors_at_start);
   end
endtask

task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall,
                            input axi_resp_t want_resp, input string what);
   axi_resp_t resp;
   axi_write(addr, data, strb, stall, resp);
   expect_range(resp, want_resp, want_resp, what);
endtask

// data is only compared on an accepted read.
task automatic read_expect(input logic [7:0] addr, input logic [31:0] want,
                           input axi_resp_t want_resp, input string what);
   logic [31:0] data;
   axi_resp_t   resp;
   axi_read(addr, data, resp);
   expect_range(resp, want_resp, want_resp, what);
   if (want_resp == resp_okay) begin
      expect_range(data, want, want, what);
   end
endtask

task automatic run_tests();
   time_t     value;
   time_t     got;
   time_t     t0;
   axi_resp_t resp;

   test_start();
   repeat (50) next_cycle();
   test_end("free running");

   test_start();
   value = {$urandom, $urandom};
   write_expect(reg_time_hi, value[63:32], 4'hf, 0, resp_okay, "time_hi write");
   write_expect(reg_time_lo, value[31:0], 4'hf, 0, resp_okay, "time_lo write");
   exp_value    = value;
   load_pending = 1'b1;
   // the jump follows the write response closely, so the watch starts right after it.
   axi_write(reg_time_ctrl, 32'h1, 4'hf, 0, resp);
   wait_load();
   expect_range(resp, resp_okay, resp_okay, "load now write");
   // the snapshot lies between the samples around the two reads.
   t0 = vita_time;
   read_time(reg_now_lo, reg_now_hi, got);
   expect_range(got, t0, vita_time, "now read");
   test_end("load now");

   test_start();
   repeat (3) begin
      value = {$urandom, $urandom};
      write_expect(reg_time_hi, value[63:32], 4'hf, 0, resp_okay, "time_hi write");
      write_expect(reg_time_lo, value[31:0], 4'hf, 0, resp_okay, "time_lo write");
      exp_value    = value;
      exp_at_pps   = 1'b1;
      load_pending = 1'b1;
      write_expect(reg_time_ctrl, 32'h2, 4'hf, 0, resp_okay, "load at pps write");
      pps_pulse(4 + $urandom % 64);
      load_pending = 1'b0;
      exp_at_pps   = 1'b0;
   end
   test_end("load at pps");

   test_start();
   repeat (4) pps_pulse(4 + $urandom % 64);
   read_time(reg_pps_lo, reg_pps_hi, got);
   expect_range(got, vita_time_lastpps, vita_time_lastpps, "pps read");
   test_end("last pps capture");

   test_start();
   value = {$urandom, $urandom};
   write_expect(reg_time_hi, value[63:32], 4'hf, 0, resp_okay, "time_hi write");
   write_expect(reg_time_lo, value[31:0], 4'hf, 0, resp_okay, "time_lo write");
   read_expect(reg_time_hi, value[63:32], resp_okay, "time_hi read");
   read_expect(reg_time_lo, value[31:0], resp_okay, "time_lo read");
   // refused accesses leave the pending value alone.
   write_expect(reg_now_lo, ~value[31:0], 4'hf, 0, resp_slverr, "now_lo write");
   write_expect(8'h20, ~value[31:0], 4'hf, 0, resp_slverr, "unmapped write");
   write_expect(reg_time_hi, ~value[63:32], 4'h3, 0, resp_slverr, "partial write");
   read_expect(reg_time_ctrl, '0, resp_slverr, "ctrl read");
   read_expect(8'h20, '0, resp_slverr, "unmapped read");
   read_expect(reg_time_hi, value[63:32], resp_okay, "time_hi after errors");
   read_expect(reg_time_lo, value[31:0], resp_okay, "time_lo after errors");
   // the write offered during the held response is never taken.
   write_expect(reg_time_lo, value[63:32], 4'hf, 6, resp_okay, "held response write");
   read_expect(reg_time_lo, value[63:32], resp_okay, "time_lo after held response");
   test_end("register access");
endtask

// File: verif/timekeeper_tb.sv
`timescale 1ns/1ps
/* time keeper testbench.
   drives the axi slave and pps input, checks the times with concurrent assertions. */
module timekeeper_tb;
   import timekeeper_pkg::*;

   localparam int clk_period = 20;
   // cycle budget of the five tests, the watchdog allows twice this.
   localparam int test_cycles = 60 + 80 + 450 + 500 + 250;

   logic        clk;
   logic        reset;
   logic        pps;
   logic [7:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   axi_resp_t   bresp;
   logic        bvalid;
   logic        bready;
   logic [7:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   axi_resp_t   rresp;
   logic        rvalid;
   logic        rready;
   time_t       vita_time;
   time_t       vita_time_lastpps;

   // expectations set by the tasks and sampled by the assertions.
   logic        load_pending;
   logic        exp_at_pps;
   time_t       exp_value;
   logic        pps_window;
   logic        chk_en;
   time_t       chk_got;
   time_t       chk_lo;
   time_t       chk_hi;
   string       chk_what;
   int          errors;
   int          errors_at_start;
   int          tests_passed;
   int          tests_failed;

   timekeeper_top timekeeper_top_i (.*);

   always #(clk_period / 2) clk = ~clk;

   // inputs change 1 ns after the rising edge.
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall, output axi_resp_t resp);
      awaddr  = addr;
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      do next_cycle(); while (!awready);
      next_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid) next_cycle();
      // a second write is offered while the response is held back.
      if (stall > 0) begin
         wdata   = ~data;
         wstrb   = 4'hf;
         awvalid = 1'b1;
         wvalid  = 1'b1;
         repeat (stall) next_cycle();
         awvalid = 1'b0;
         wvalid  = 1'b0;
      end
      resp   = bresp;
      bready = 1'b1;
      next_cycle();
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                           output axi_resp_t resp);
      araddr  = addr;
      arvalid = 1'b1;
      do next_cycle(); while (!arready);
      next_cycle();
      arvalid = 1'b0;
      while (!rvalid) next_cycle();
      data   = rdata;
      resp   = rresp;
      rready = 1'b1;
      next_cycle();
      rready = 0;
   endtask

   // low word first, the high word then comes from the hold register.
   task automatic read_time(input logic [7:0] lo_addr, input logic [7:0] hi_addr,
                            output time_t value);
      logic [31:0] lo;
      logic [31:0] hi;
      axi_resp_t   resp;
      axi_read(lo_addr, lo, resp);
      axi_read(hi_addr, hi, resp);
      value = {hi, lo};
   endtask

   // one cycle strobe for the range assertion.
   task automatic expect_range(input time_t got, input time_t lo, input time_t hi,
                               input string what);
      chk_got  = got;
      chk_lo   = lo;
      chk_hi   = hi;
      chk_what = what;
      chk_en   = 1'b1;
      next_cycle();
      chk_en   = 1'b0;
   endtask

   // raise pps after a low gap and wait for the capture to change.
   task automatic pps_pulse(input int gap);
      time_t last;
      last = vita_time_lastpps;
      repeat (gap) next_cycle();
      pps        = 1'b1;
      pps_window = 1'b1;
      while (vita_time_lastpps == last) next_cycle();
      next_cycle();
      pps_window = 1'b0;
      repeat (2) next_cycle();
      pps = 1'b0;
   endtask

   // waits for the counter to leave its +1 sequence.
   task automatic wait_load();
      time_t prev;
      prev = vita_time;
      next_cycle();
      while (vita_time == prev + 64'd1) begin
         prev = vita_time;
         next_cycle();
      end
      next_cycle();
      load_pending = 1'b0;
   endtask

`include "timekeeper_tests.svh"

   // both times start at zero.
   reset_zero: assert property (@(posedge clk)
      $fell(reset) |-> vita_time == 64'd0 && vita_time_lastpps == 64'd0)
      else begin
         errors++;
         $display("MISMATCH %0t: times not zero after reset", $time);
      end

   // +1 per cycle, a jump only to the armed value, an at-pps jump only with the capture.
   count_step: assert property (@(posedge clk) disable iff (reset)
      1 |=> vita_time == $past(vita_time) + 64'd1 ||
         (load_pending && vita_time == exp_value &&
          (!exp_at_pps || vita_time_lastpps != $past(vita_time_lastpps))))
      else begin
         errors++;
         $display("MISMATCH %0t: vita_time %h after %h", $time, vita_time, $past(vita_time));
      end

   // capture changes once per pps rise and matches the counter.
   pps_capture: assert property (@(posedge clk) disable iff (reset)
      vita_time_lastpps != $past(vita_time_lastpps) |->
         pps_window && vita_time_lastpps == vita_time &&
         (!load_pending || vita_time == exp_value))
      else begin
         errors++;
         $display("MISMATCH %0t: vita_time_lastpps %h with vita_time %h", $time,
                  vita_time_lastpps, vita_time);
      end

   value_range: assert property (@(posedge clk) chk_en |-> chk_got >= chk_lo && chk_got <= chk_hi)
      else begin
         errors++;
         $display("MISMATCH %0t: %s got %h expected %h to %h", $time, chk_what, chk_got,
                  chk_lo, chk_hi);
      end

   // a held response blocks new writes.
   bvalid_held: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid)
      else begin
         errors++;
         $display("bvalid dropped before bready at %0t", $time);
      end

   write_blocked: assert property (@(posedge clk) disable iff (reset)
      bvalid |-> !awready && !wready)
      else begin
         errors++;
         $display("write accepted while a response was pending at %0t", $time);
      end

   initial begin
      void'($urandom(32'h2992303e));
      clk = 1'b0;
      reset = 1'b1;
      pps = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      load_pending = 1'b0;
      exp_at_pps = 1'b0;
      exp_value = '0;
      pps_window = 1'b0;
      chk_en = 1'b0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      run_tests();
      $display("%0d tests ok, %0d tests with errors", tests_passed, tests_failed);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog.
   initial begin
      #(2 * test_cycles * clk_period);
      $display("run timed out before the tests finished");
      $display("Test failed");
      $finish;
   end

endmodule

// File: timekeeper_top.f
+incdir+verif
common/timekeeper_pkg.sv
logic/pps_detect.sv
timekeeper/timekeeper_regs.sv
timekeeper/time_counter.sv
timekeeper/timekeeper_top.sv
verif/timekeeper_tb.sv
